// ==== pe_array_pkg.sv ====
package pe_array_pkg;

    // array geometry
    localparam int LANE_COUNT = 28;
    localparam int TAP_COUNT  = 3;
    localparam int SLOT_COUNT = LANE_COUNT * TAP_COUNT; // 84 slots per buffer

    // datapath widths
    localparam int IFMAP_W  = 8;
    localparam int WEIGHT_W = 8;
    localparam int PSUM_W   = 20;

    localparam int SLOT_ADDR_W = 7;
    localparam int LANE_ADDR_W = 5;

    typedef logic [IFMAP_W-1:0]         ifmap_t;  // unsigned activation
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [PSUM_W-1:0]   psum_t;

    typedef logic [SLOT_ADDR_W-1:0] slot_addr_t;
    typedef logic [LANE_ADDR_W-1:0] lane_addr_t;

    // single-word buffer write ports
    typedef struct packed {
        logic       wen;
        slot_addr_t addr;
        ifmap_t     data;
    } ifmap_wr_t;

    typedef struct packed {
        logic       wen;
        slot_addr_t addr;
        weight_t    data;
    } weight_wr_t;

    // operands of one lane, tap k in element k
    typedef struct packed {
        ifmap_t  [TAP_COUNT-1:0] ifmap;
        weight_t [TAP_COUNT-1:0] weight;
    } lane_operand_t;

endpackage

// ==== operand_buffer.sv ====
`timescale 1ns/1ps

module operand_buffer (
    input  logic                         clk,
    input  logic                         rst,
    input  pe_array_pkg::ifmap_wr_t      i_ifmap_wr,
    input  pe_array_pkg::weight_wr_t     i_weight_wr,
    input  logic                         i_ifmap_clear,
    input  logic                         i_weight_clear,
    input  logic                         i_align_conv1,
    output pe_array_pkg::lane_operand_t  o_lane_operand [pe_array_pkg::LANE_COUNT]
);
    import pe_array_pkg::*;

    ifmap_t  ifmap_buf  [SLOT_COUNT];
    weight_t weight_buf [SLOT_COUNT];

    logic ifmap_wr_ok;
    logic weight_wr_ok;

    // addresses past the last slot are dropped
    assign ifmap_wr_ok  = i_ifmap_wr.wen && (i_ifmap_wr.addr < SLOT_COUNT);
    assign weight_wr_ok = i_weight_wr.wen && (i_weight_wr.addr < SLOT_COUNT);

    // ifmap buffer: clear, then align, then write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SLOT_COUNT; s++) begin
                ifmap_buf[s] <= '0;
            end
        end else if (i_ifmap_clear) begin
            for (int s = 0; s < SLOT_COUNT; s++) begin
                ifmap_buf[s] <= '0;
            end
        end else if (i_align_conv1) begin
            // sliding window, lane j sees slots j..j+2
            for (int j = 0; j < LANE_COUNT; j++) begin
                for (int k = 0; k < TAP_COUNT; k++) begin
                    ifmap_buf[j*TAP_COUNT+k] <= ifmap_buf[j+k];
                end
            end
        end else if (ifmap_wr_ok) begin
            ifmap_buf[i_ifmap_wr.addr] <= i_ifmap_wr.data;
        end
    end

    // weight buffer, same priority
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SLOT_COUNT; s++) begin
                weight_buf[s] <= '0;
            end
        end else if (i_weight_clear) begin
            for (int s = 0; s < SLOT_COUNT; s++) begin
                weight_buf[s] <= '0;
            end
        end else if (i_align_conv1) begin
            // lane 0 kernel broadcast to every lane
            for (int j = 0; j < LANE_COUNT; j++) begin
                for (int k = 0; k < TAP_COUNT; k++) begin
                    weight_buf[j*TAP_COUNT+k] <= weight_buf[k];
                end
            end
        end else if (weight_wr_ok) begin
            weight_buf[i_weight_wr.addr] <= i_weight_wr.data;
        end
    end

    // lane j, tap k <- slot j*3+k
    always_comb begin
        for (int j = 0; j < LANE_COUNT; j++) begin
            for (int k = 0; k < TAP_COUNT; k++) begin
                o_lane_operand[j].ifmap[k]  = ifmap_buf[j*TAP_COUNT+k];
                o_lane_operand[j].weight[k] = weight_buf[j*TAP_COUNT+k];
            end
        end
    end

endmodule

// ==== pe_lane.sv ====
`timescale 1ns/1ps

module pe_lane (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_load_ifmap,
    input  logic                        i_load_weight,
    input  logic                        i_clear,
    input  pe_array_pkg::lane_operand_t i_operand,
    output pe_array_pkg::psum_t         o_psum
);
    import pe_array_pkg::*;

    // operand registers of the three PEs
    ifmap_t  [TAP_COUNT-1:0] ifmap_q;
    weight_t [TAP_COUNT-1:0] weight_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ifmap_q <= '0;
        end else if (i_clear) begin
            ifmap_q <= '0;
        end else if (i_load_ifmap) begin
            ifmap_q <= i_operand.ifmap;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weight_q <= '0;
        end else if (i_clear) begin // clear wins over load
            weight_q <= '0;
        end else if (i_load_weight) begin
            weight_q <= i_operand.weight;
        end
    end

    // dot product over the taps
    // ifmap is zero-extended so the product stays signed
    always_comb begin
        o_psum = '0;
        for (int k = 0; k < TAP_COUNT; k++) begin
            o_psum = o_psum + psum_t'($signed({1'b0, ifmap_q[k]})) * psum_t'(weight_q[k]);
        end
    end

endmodule

// ==== psum_buffer.sv ====
`timescale 1ns/1ps

module psum_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_wen,
    input  pe_array_pkg::psum_t      i_psum [pe_array_pkg::LANE_COUNT],
    input  pe_array_pkg::lane_addr_t i_rd_addr,
    output pe_array_pkg::psum_t      o_rd_data
);
    import pe_array_pkg::*;

    psum_t psum_q [LANE_COUNT];

    // snapshot of every lane at once
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int j = 0; j < LANE_COUNT; j++) begin
                psum_q[j] <= '0;
            end
        end else if (i_wen) begin
            for (int j = 0; j < LANE_COUNT; j++) begin
                psum_q[j] <= i_psum[j];
            end
        end
    end

    always_comb begin
        if (i_rd_addr < LANE_COUNT) begin
            o_rd_data = psum_q[i_rd_addr];
        end else begin
            o_rd_data = '0; // lanes 28..31 do not exist
        end
    end

endmodule

// ==== pe_array_top.sv ====
`timescale 1ns/1ps

module pe_array_top (
    input  logic                     clk,
    input  logic                     rst,
    input  pe_array_pkg::ifmap_wr_t  i_ifmap_wr,
    input  pe_array_pkg::weight_wr_t i_weight_wr,
    input  logic                     i_ifmap_clear,
    input  logic                     i_weight_clear,
    input  logic                     i_align_conv1,
    input  logic                     i_pe_load_ifmap,
    input  logic                     i_pe_load_weight,
    input  logic                     i_pe_clear,
    input  logic                     i_psum_wen,
    input  pe_array_pkg::lane_addr_t i_psum_rd_addr,
    output pe_array_pkg::psum_t      o_psum_rd_data
);
    import pe_array_pkg::*;

    lane_operand_t lane_operand [LANE_COUNT]; // buffer -> lanes
    psum_t         lane_psum    [LANE_COUNT]; // lanes -> psum buffer

    operand_buffer u_operand_buffer (
        .clk            (clk),
        .rst            (rst),
        .i_ifmap_wr     (i_ifmap_wr),
        .i_weight_wr    (i_weight_wr),
        .i_ifmap_clear  (i_ifmap_clear),
        .i_weight_clear (i_weight_clear),
        .i_align_conv1  (i_align_conv1),
        .o_lane_operand (lane_operand)
    );

    for (genvar j = 0; j < LANE_COUNT; j++) begin : g_lane
        pe_lane u_pe_lane (
            .clk           (clk),
            .rst           (rst),
            .i_load_ifmap  (i_pe_load_ifmap),
            .i_load_weight (i_pe_load_weight),
            .i_clear       (i_pe_clear),
            .i_operand     (lane_operand[j]),
            .o_psum        (lane_psum[j])
        );
    end

    psum_buffer u_psum_buffer (
        .clk       (clk),
        .rst       (rst),
        .i_wen     (i_psum_wen),
        .i_psum    (lane_psum),
        .i_rd_addr (i_psum_rd_addr),
        .o_rd_data (o_psum_rd_data)
    );

endmodule

// ==== pe_array_chk.sv ====
`timescale 1ns/1ps

module pe_array_chk (
    input logic                     clk,
    input logic                     rst,
    input logic                     i_ifmap_clear,
    input logic                     i_weight_clear,
    input logic                     i_align_conv1,
    input logic                     i_pe_load_ifmap,
    input logic                     i_pe_load_weight,
    input logic                     i_pe_clear,
    input pe_array_pkg::lane_addr_t i_psum_rd_addr
);
    import pe_array_pkg::*;

    int fail_count = 0;

    // align and clear on one edge, clear would silently win
    a_align_no_clear: assert property (@(posedge clk) disable iff (rst)
        i_align_conv1 |-> !(i_ifmap_clear || i_weight_clear))
        else begin
            fail_count++;
            $error("align asserted together with a buffer clear");
        end

    a_rd_addr_range: assert property (@(posedge clk) disable iff (rst)
        i_psum_rd_addr < LANE_COUNT) // no lane behind 28..31
        else begin
            fail_count++;
            $error("psum read address past the last lane");
        end

    a_clear_no_load: assert property (@(posedge clk) disable iff (rst)
        i_pe_clear |-> !(i_pe_load_ifmap || i_pe_load_weight))
        else begin
            fail_count++;
            $error("lane clear asserted together with a load");
        end

endmodule

bind pe_array_top pe_array_chk u_chk (
    .clk              (clk),
    .rst              (rst),
    .i_ifmap_clear    (i_ifmap_clear),
    .i_weight_clear   (i_weight_clear),
    .i_align_conv1    (i_align_conv1),
    .i_pe_load_ifmap  (i_pe_load_ifmap),
    .i_pe_load_weight (i_pe_load_weight),
    .i_pe_clear       (i_pe_clear),
    .i_psum_rd_addr   (i_psum_rd_addr)
);

// ==== tb_pe_array.sv ====
`timescale 1ns/1ps

module tb_pe_array;
    import pe_array_pkg::*;

    logic       clk;
    logic       rst;
    ifmap_wr_t  i_ifmap_wr;
    weight_wr_t i_weight_wr;
    logic       i_ifmap_clear;
    logic       i_weight_clear;
    logic       i_align_conv1;
    logic       i_pe_load_ifmap;
    logic       i_pe_load_weight;
    logic       i_pe_clear;
    logic       i_psum_wen;
    lane_addr_t i_psum_rd_addr;
    psum_t      o_psum_rd_data;

    int sh_ifmap  [SLOT_COUNT]; // shadow buffers
    int sh_weight [SLOT_COUNT];
    int lane_exp  [LANE_COUNT]; // what each lane holds
    int exp_psum  [LANE_COUNT]; // what the psum buffer holds

    integer seed;
    int     errors;
    int     checks;
    int     checks_target;
    logic   cmp_en;
    int     cmp_lane;
    int     cmp_exp;

    pe_array_top dut0 (
        .clk              (clk),
        .rst              (rst),
        .i_ifmap_wr       (i_ifmap_wr),
        .i_weight_wr      (i_weight_wr),
        .i_ifmap_clear    (i_ifmap_clear),
        .i_weight_clear   (i_weight_clear),
        .i_align_conv1    (i_align_conv1),
        .i_pe_load_ifmap  (i_pe_load_ifmap),
        .i_pe_load_weight (i_pe_load_weight),
        .i_pe_clear       (i_pe_clear),
        .i_psum_wen       (i_psum_wen),
        .i_psum_rd_addr   (i_psum_rd_addr),
        .o_psum_rd_data   (o_psum_rd_data)
    );

    always #2 clk = ~clk;

    // dot product of one lane's three slots
    function automatic int expected_psum(input int lane, input int ifm [SLOT_COUNT],
                                         input int wgt [SLOT_COUNT]);
        int acc;
        acc = 0;
        for (int k = 0; k < TAP_COUNT; k++) begin
            acc += ifm[lane*TAP_COUNT+k] * wgt[lane*TAP_COUNT+k];
        end
        return acc;
    endfunction

    // compare on the falling edge, address settled since the rising one
    always @(negedge clk) begin
        if (cmp_en) begin
            checks++;
            assert (int'(o_psum_rd_data) == cmp_exp) else begin
                errors++;
                $display("[FAIL] %0t lane %0d read %0d, expected %0d",
                         $time, cmp_lane, o_psum_rd_data, cmp_exp);
            end
        end
    end

    task automatic fill_buffers(input bit do_ifmap, input bit do_weight);
        int iv;
        int wv;
        for (int s = 0; s < SLOT_COUNT; s++) begin
            iv = $random(seed) & 255;
            wv = ($random(seed) & 255) - 128; // -128..127
            @(posedge clk);
            i_ifmap_wr  <= '{wen: do_ifmap, addr: slot_addr_t'(s), data: ifmap_t'(iv)};
            i_weight_wr <= '{wen: do_weight, addr: slot_addr_t'(s), data: weight_t'(wv)};
            if (do_ifmap) begin
                sh_ifmap[s] = iv;
            end
            if (do_weight) begin
                sh_weight[s] = wv;
            end
        end
        @(posedge clk);
        i_ifmap_wr.wen  <= 1'b0;
        i_weight_wr.wen <= 1'b0;
    endtask

    task automatic align_conv1();
        int old_i [SLOT_COUNT];
        int old_w [SLOT_COUNT];
        old_i = sh_ifmap;
        old_w = sh_weight;
        for (int j = 0; j < LANE_COUNT; j++) begin
            for (int k = 0; k < TAP_COUNT; k++) begin
                sh_ifmap[j*TAP_COUNT+k]  = old_i[j+k];
                sh_weight[j*TAP_COUNT+k] = old_w[k]; // lane 0 kernel everywhere
            end
        end
        @(posedge clk);
        i_align_conv1 <= 1'b1;
        @(posedge clk);
        i_align_conv1 <= 1'b0;
    endtask

    task automatic clear_ifmap();
        for (int s = 0; s < SLOT_COUNT; s++) begin
            sh_ifmap[s] = 0;
        end
        @(posedge clk);
        i_ifmap_clear <= 1'b1;
        @(posedge clk);
        i_ifmap_clear <= 1'b0;
    endtask

    task automatic clear_weight();
        for (int s = 0; s < SLOT_COUNT; s++) begin
            sh_weight[s] = 0;
        end
        @(posedge clk);
        i_weight_clear <= 1'b1;
        @(posedge clk);
        i_weight_clear <= 1'b0;
    endtask

    task automatic load_lanes();
        for (int j = 0; j < LANE_COUNT; j++) begin
            lane_exp[j] = expected_psum(j, sh_ifmap, sh_weight);
        end
        @(posedge clk);
        i_pe_load_ifmap  <= 1'b1;
        i_pe_load_weight <= 1'b1;
        @(posedge clk);
        i_pe_load_ifmap  <= 1'b0;
        i_pe_load_weight <= 1'b0;
    endtask

    task automatic clear_lanes();
        for (int j = 0; j < LANE_COUNT; j++) begin
            lane_exp[j] = 0;
        end
        @(posedge clk);
        i_pe_clear <= 1'b1;
        @(posedge clk);
        i_pe_clear <= 1'b0;
    endtask

    task automatic capture();
        exp_psum = lane_exp;
        @(posedge clk);
        i_psum_wen <= 1'b1;
        @(posedge clk);
        i_psum_wen <= 1'b0;
    endtask

    task automatic wait_checks();
        int n;
        n = 0;
        while (checks < checks_target && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (checks < checks_target) begin
            $display("timeout: compare process did not finish the lane sweep");
            $display("TEST FAIL");
            $finish;
        end
    endtask

    // walk every lane address through the compare process
    task automatic compare_all();
        checks_target += LANE_COUNT;
        for (int j = 0; j < LANE_COUNT; j++) begin
            @(posedge clk);
            i_psum_rd_addr <= lane_addr_t'(j);
            cmp_lane       <= j;
            cmp_exp        <= exp_psum[j];
            cmp_en         <= 1'b1;
        end
        @(posedge clk);
        cmp_en <= 1'b0;
        wait_checks();
    endtask

    initial begin
        clk              = 1'b0;
        rst              = 1'b1;
        i_ifmap_wr       = '0;
        i_weight_wr      = '0;
        i_ifmap_clear    = 1'b0;
        i_weight_clear   = 1'b0;
        i_align_conv1    = 1'b0;
        i_pe_load_ifmap  = 1'b0;
        i_pe_load_weight = 1'b0;
        i_pe_clear       = 1'b0;
        i_psum_wen       = 1'b0;
        i_psum_rd_addr   = '0;
        seed             = 72;
        errors           = 0;
        checks           = 0;
        checks_target    = 0;
        cmp_en           = 1'b0;
        cmp_lane         = 0;
        cmp_exp          = 0;
        for (int s = 0; s < SLOT_COUNT; s++) begin
            sh_ifmap[s]  = 0;
            sh_weight[s] = 0;
        end
        for (int j = 0; j < LANE_COUNT; j++) begin
            lane_exp[j] = 0;
            exp_psum[j] = 0;
        end

        for (int c = 0; c < 16; c++) begin
            @(posedge clk);
        end
        rst <= 1'b0;
        @(posedge clk);

        compare_all(); // everything zero out of reset

        fill_buffers(1'b1, 1'b1);
        load_lanes();
        capture();
        compare_all();

        // conv1 window over the pre-align values
        fill_buffers(1'b1, 1'b1);
        align_conv1();
        load_lanes();
        capture();
        compare_all();

        clear_lanes();
        capture();
        compare_all();

        // weights survive an ifmap clear
        clear_ifmap();
        load_lanes();
        capture();
        compare_all();
        fill_buffers(1'b1, 1'b0);
        load_lanes();
        capture();
        compare_all();

        // reload without capture, reads stay put
        fill_buffers(1'b1, 1'b1);
        load_lanes();
        compare_all();
        capture();
        compare_all();

        // cleared weights zero every lane
        clear_weight();
        load_lanes();
        capture();
        compare_all();

        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, dut0.u_chk.fail_count);
        if (errors == 0 && dut0.u_chk.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
pe_array_pkg.sv
operand_buffer.sv
pe_lane.sv
psum_buffer.sv
pe_array_top.sv
pe_array_chk.sv
tb_pe_array.sv
